//--- src/cache_arrays.sv
`timescale 1ns/10ps
`default_nettype none

module cache_arrays (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  cache_pkg::word_t      i_req_addr,
    input  logic                  i_fill_we,
    input  cache_pkg::word_idx_t  i_fill_word,
    input  cache_pkg::word_t      i_fill_data,
    input  cache_pkg::word_t      i_line_addr,
    input  logic                  i_st_we,
    input  logic                  i_st_way,
    input  cache_pkg::word_t      i_st_addr,
    input  cache_pkg::mask_t      i_st_mask,
    input  cache_pkg::word_t      i_st_wdata,
    input  logic                  i_touch,
    input  logic                  i_touch_way,
    output logic                  o_hit,
    output logic                  o_hit_way,
    output cache_pkg::word_t      o_rdata,
    output logic                  o_victim_way,
    output cache_pkg::word_t      o_merged
);

    //////////////////////////////
    // storage
    //////////////////////////////

    cache_pkg::word_t data_mem [2][cache_pkg::num_sets][cache_pkg::words_per_line];
    cache_pkg::tag_t  tag_mem  [2][cache_pkg::num_sets];
    logic [1:0]       valid_q  [cache_pkg::num_sets];   // one bit per way
    logic [cache_pkg::num_sets-1:0] victim_q;          // the way not used most recently

    cache_pkg::set_idx_t  req_set;
    cache_pkg::tag_t      req_tag;
    cache_pkg::word_idx_t req_word;
    cache_pkg::set_idx_t  line_set;
    cache_pkg::tag_t      line_tag;
    cache_pkg::set_idx_t  st_set;
    cache_pkg::word_idx_t st_word;
    logic                 hit0;
    logic                 hit1;
    cache_pkg::word_t     old_word;

    assign req_set  = i_req_addr[cache_pkg::offset_bits +: cache_pkg::set_bits];
    assign req_tag  = i_req_addr[31 -: cache_pkg::tag_bits];
    assign req_word = i_req_addr[3:2];
    assign line_set = i_line_addr[cache_pkg::offset_bits +: cache_pkg::set_bits];
    assign line_tag = i_line_addr[31 -: cache_pkg::tag_bits];
    assign st_set   = i_st_addr[cache_pkg::offset_bits +: cache_pkg::set_bits];
    assign st_word  = i_st_addr[3:2];

    //////////////////////////////
    // lookup
    //////////////////////////////

    assign hit0      = valid_q[req_set][0] && (tag_mem[0][req_set] == req_tag);
    assign hit1      = valid_q[req_set][1] && (tag_mem[1][req_set] == req_tag);
    assign o_hit     = hit0 || hit1;
    assign o_hit_way = hit1;                               // way 0 when neither hits
    assign o_rdata   = data_mem[o_hit_way][req_set][req_word];

    // victim of the set the fill targets
    assign o_victim_way = victim_q[line_set];

    // byte lane merge of a store into the word it replaces
    assign old_word = data_mem[i_st_way][st_set][st_word];
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            o_merged[8*b +: 8] = i_st_mask[b] ? i_st_wdata[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    //////////////////////////////
    // updates
    //////////////////////////////

    // fills and stores never fall in the same cycle
    always_ff @(posedge i_clk) begin
        if (i_fill_we) begin
            data_mem[o_victim_way][line_set][i_fill_word] <= i_fill_data;
            tag_mem[o_victim_way][line_set]               <= line_tag;
        end
        if (i_st_we) begin
            data_mem[i_st_way][st_set][st_word] <= o_merged;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                valid_q[s] <= 2'b00;
            end
            victim_q <= '0;              // every set starts out replacing way 0
        end else begin
            if (i_fill_we) begin
                // the way stays invalid until its last word lands
                valid_q[line_set][o_victim_way] <= (i_fill_word == 2'd3);
                if (i_fill_word == 2'd3) begin
                    victim_q[line_set] <= ~victim_q[line_set];
                end
            end
            if (i_touch) begin
                victim_q[req_set] <= ~i_touch_way; // the other way becomes the victim
            end
        end
    end

    // a fill only starts on a miss, so a line never lives in both ways
    a_one_way: assert property (@(posedge i_clk) disable iff (i_rst)
        !(hit0 && hit1));

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
    input  logic              i_clk,
    input  logic              i_rst,
    input  cache_pkg::word_t  i_req_addr,
    input  logic              i_req_ren,
    input  logic              i_req_wen,
    input  cache_pkg::mask_t  i_req_mask,
    input  cache_pkg::word_t  i_req_wdata,
    input  logic              i_mem_ready,
    input  logic              i_hit,
    input  logic              i_hit_way,
    input  logic              i_victim_way,
    input  cache_pkg::word_t  i_merged,      // old word merged with the store bytes
    input  logic              i_fill_rd_req,
    input  cache_pkg::word_t  i_fill_rd_addr,
    input  logic              i_fill_done,
    output logic              o_busy,
    output cache_pkg::word_t  o_mem_addr,
    output logic              o_mem_ren,
    output logic              o_mem_wen,
    output cache_pkg::word_t  o_mem_wdata,
    output logic              o_fill_start,
    output cache_pkg::word_t  o_line_addr,
    output logic              o_st_we,
    output logic              o_st_way,
    output cache_pkg::word_t  o_st_addr,
    output cache_pkg::mask_t  o_st_mask,
    output cache_pkg::word_t  o_st_wdata,
    output logic              o_touch,
    output logic              o_touch_way
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t next_state;
    cache_pkg::word_t       addr_q;    // request captured on a miss
    cache_pkg::mask_t       mask_q;
    cache_pkg::word_t       wdata_q;
    logic                   store_q;   // the miss was a store, so a write-through follows the fill
    logic                   way_q;     // the way the refill lands in
    logic                   req;
    logic                   in_lookup;

    assign req       = i_req_ren ^ i_req_wen; // exactly one strobe makes a request
    assign in_lookup = (state == cache_pkg::st_lookup);

    // in lookup the store port follows the live request, afterwards the captured one
    assign o_st_way    = in_lookup ? i_hit_way   : way_q;
    assign o_st_addr   = in_lookup ? i_req_addr  : addr_q;
    assign o_st_mask   = in_lookup ? i_req_mask  : mask_q;
    assign o_st_wdata  = in_lookup ? i_req_wdata : wdata_q;
    assign o_line_addr = {o_st_addr[31:cache_pkg::offset_bits], {cache_pkg::offset_bits{1'b0}}};

    //////////////////////////////
    // request classification
    //////////////////////////////

    always_comb begin
        next_state   = state;
        o_busy       = 1'b0;
        o_mem_ren    = 1'b0;
        o_mem_wen    = 1'b0;
        o_mem_addr   = {o_st_addr[31:2], 2'b00}; // memory only takes aligned words
        o_mem_wdata  = i_merged;                 // write-through always sends the full word
        o_fill_start = 1'b0;
        o_st_we      = 1'b0;
        o_touch      = 1'b0;
        o_touch_way  = i_hit_way;
        case (state)
            cache_pkg::st_lookup: begin
                if (req) begin
                    if (!i_hit) begin
                        // any miss stalls at once and starts the line fill
                        o_busy       = 1'b1;
                        o_fill_start = 1'b1;
                        next_state   = cache_pkg::st_refill;
                    end else if (i_req_ren) begin
                        o_touch = 1'b1; // load hit, data is already on o_rdata
                    end else if (i_mem_ready) begin
                        o_st_we   = 1'b1; // store hit, cache and memory in the same cycle
                        o_mem_wen = 1'b1;
                        o_touch   = 1'b1;
                    end else begin
                        o_busy = 1'b1;    // store hit has to wait for memory
                    end
                end
            end
            cache_pkg::st_refill: begin
                o_busy     = 1'b1;
                o_mem_ren  = i_fill_rd_req;  // the sequencer only asks in ready cycles
                o_mem_addr = i_fill_rd_addr;
                if (i_fill_done) begin
                    next_state = store_q ? cache_pkg::st_write_through : cache_pkg::st_lookup;
                end
            end
            cache_pkg::st_write_through: begin
                o_busy = 1'b1;
                if (i_mem_ready) begin
                    // merge the store into the refilled line and send it out together
                    o_st_we    = 1'b1;
                    o_mem_wen  = 1'b1;
                    next_state = cache_pkg::st_lookup;
                end
            end
            default: next_state = cache_pkg::st_lookup;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= cache_pkg::st_lookup;
        end else begin
            state <= next_state;
        end
    end

    // capture the request and the way chosen for the fill
    always_ff @(posedge i_clk) begin
        if (o_fill_start) begin
            addr_q  <= i_req_addr;
            mask_q  <= i_req_mask;
            wdata_q <= i_req_wdata;
            store_q <= i_req_wen;
            way_q   <= i_victim_way; // victim flips when the fill ends, so keep it here
        end
    end

    // memory takes a single pulse per cycle and only while it is ready
    a_mem_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_mem_ren || o_mem_wen) |-> (i_mem_ready && !(o_mem_ren && o_mem_wen)));

endmodule

`default_nettype wire

//--- src/cache_pkg.sv
`default_nettype none

package cache_pkg;

    //////////////////////////////
    // cache geometry
    //////////////////////////////

    // 16 byte lines, 32 sets, two ways, so 1 KiB of data
    localparam int offset_bits    = 4;
    localparam int set_bits       = 5;
    localparam int tag_bits       = 32 - offset_bits - set_bits; // 23 bit tag
    localparam int num_sets       = 2 ** set_bits;
    localparam int words_per_line = 4;

    //////////////////////////////
    // address fields and payload
    //////////////////////////////

    typedef logic [31:0]           word_t;     // a data word or a byte address
    typedef logic [tag_bits-1:0]   tag_t;      // upper address bits kept per way
    typedef logic [set_bits-1:0]   set_idx_t;  // selects one of the sets
    typedef logic [1:0]            word_idx_t; // word within a line
    typedef logic [3:0]            mask_t;     // one enable per byte lane

    // controller states of the blocking cache
    typedef enum logic [1:0] {
        st_lookup,        // idle, comparing tags of the live request
        st_refill,        // line fill running in the refill sequencer
        st_write_through  // store miss waiting for memory to take its write
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/cache_refill.sv
`timescale 1ns/10ps
`default_nettype none

module cache_refill (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_fill_start,
    input  cache_pkg::word_t      i_line_addr,
    input  logic                  i_mem_ready,
    input  logic                  i_mem_valid,
    input  cache_pkg::word_t      i_mem_rdata,
    output logic                  o_rd_req,
    output cache_pkg::word_t      o_rd_addr,
    output logic                  o_fill_we,
    output cache_pkg::word_idx_t  o_fill_word,
    output cache_pkg::word_t      o_fill_data,
    output logic                  o_fill_done
);

    logic                 active;      // a line fill is running
    logic                 outstanding; // a read went out and its word has not come back
    cache_pkg::word_idx_t cnt;         // next word of the line
    cache_pkg::word_t     base;        // line base latched at the start

    // one read at a time, and only when memory can take it
    assign o_rd_req  = active && !outstanding && i_mem_ready;
    assign o_rd_addr = {base[31:cache_pkg::offset_bits], cnt, 2'b00};

    // every returning word goes straight into the victim way
    assign o_fill_we   = outstanding && i_mem_valid;
    assign o_fill_word = cnt;
    assign o_fill_data = i_mem_rdata;
    assign o_fill_done = o_fill_we &&
                         (cnt == cache_pkg::word_idx_t'(cache_pkg::words_per_line - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            active      <= 1'b0;
            outstanding <= 1'b0;
            cnt         <= '0;
        end else begin
            if (i_fill_start) begin
                active <= 1'b1;
                cnt    <= '0; // fills always run from word 0 of the line
            end
            if (o_rd_req) begin
                outstanding <= 1'b1;
            end
            if (o_fill_we) begin
                outstanding <= 1'b0;
                cnt         <= cnt + 2'd1;
                if (o_fill_done) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_fill_start) begin
            base <= i_line_addr;
        end
    end

    // the cache reads only through this block, so memory may not answer unasked
    a_valid_asked: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mem_valid |-> outstanding);

endmodule

`default_nettype wire

//--- src/cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  logic              i_clk,
    input  logic              i_rst,
    // hart side
    input  cache_pkg::word_t  i_req_addr,
    input  logic              i_req_ren,
    input  logic              i_req_wen,
    input  cache_pkg::mask_t  i_req_mask,
    input  cache_pkg::word_t  i_req_wdata,
    output logic              o_busy,
    output cache_pkg::word_t  o_res_rdata,
    // memory side, word granular
    input  logic              i_mem_ready,
    output cache_pkg::word_t  o_mem_addr,
    output logic              o_mem_ren,
    output logic              o_mem_wen,
    output cache_pkg::word_t  o_mem_wdata,
    input  cache_pkg::word_t  i_mem_rdata,
    input  logic              i_mem_valid
);

    // controller and refill sequencer handshake
    logic                 fill_start;
    cache_pkg::word_t     line_addr;
    logic                 fill_rd_req;
    cache_pkg::word_t     fill_rd_addr;
    logic                 fill_done;

    // refill sequencer into the arrays
    logic                 fill_we;
    cache_pkg::word_idx_t fill_word;
    cache_pkg::word_t     fill_data;

    // lookup results back to the controller
    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    cache_pkg::word_t     merged;

    // store and replacement updates from the controller
    logic                 st_we;
    logic                 st_way;
    cache_pkg::word_t     st_addr;
    cache_pkg::mask_t     st_mask;
    cache_pkg::word_t     st_wdata;
    logic                 touch;
    logic                 touch_way;

    cache_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_req_addr     (i_req_addr),
        .i_req_ren      (i_req_ren),
        .i_req_wen      (i_req_wen),
        .i_req_mask     (i_req_mask),
        .i_req_wdata    (i_req_wdata),
        .i_mem_ready    (i_mem_ready),
        .i_hit          (hit),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .i_merged       (merged),
        .i_fill_rd_req  (fill_rd_req),
        .i_fill_rd_addr (fill_rd_addr),
        .i_fill_done    (fill_done),
        .o_busy         (o_busy),
        .o_mem_addr     (o_mem_addr),
        .o_mem_ren      (o_mem_ren),
        .o_mem_wen      (o_mem_wen),
        .o_mem_wdata    (o_mem_wdata),
        .o_fill_start   (fill_start),
        .o_line_addr    (line_addr),
        .o_st_we        (st_we),
        .o_st_way       (st_way),
        .o_st_addr      (st_addr),
        .o_st_mask      (st_mask),
        .o_st_wdata     (st_wdata),
        .o_touch        (touch),
        .o_touch_way    (touch_way)
    );

    cache_refill u_refill (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_fill_start (fill_start),
        .i_line_addr  (line_addr),
        .i_mem_ready  (i_mem_ready),
        .i_mem_valid  (i_mem_valid),
        .i_mem_rdata  (i_mem_rdata),
        .o_rd_req     (fill_rd_req),
        .o_rd_addr    (fill_rd_addr),
        .o_fill_we    (fill_we),
        .o_fill_word  (fill_word),
        .o_fill_data  (fill_data),
        .o_fill_done  (fill_done)
    );

    cache_arrays u_arrays (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req_addr   (i_req_addr),
        .i_fill_we    (fill_we),
        .i_fill_word  (fill_word),
        .i_fill_data  (fill_data),
        .i_line_addr  (line_addr),
        .i_st_we      (st_we),
        .i_st_way     (st_way),
        .i_st_addr    (st_addr),
        .i_st_mask    (st_mask),
        .i_st_wdata   (st_wdata),
        .i_touch      (touch),
        .i_touch_way  (touch_way),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_rdata      (o_res_rdata),
        .o_victim_way (victim_way),
        .o_merged     (merged)
    );

endmodule

`default_nettype wire

//--- tb.f
src/cache_pkg.sv
src/cache_arrays.sv
src/cache_refill.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/tb_mem_model.sv
testbench/tb_cache.sv

//--- testbench/tb_cache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache;

    localparam logic [31:0] lcg_seed = 32'h21befb5a;
    localparam logic [31:0] mem_base = 32'h0001_0000;
    localparam int n_directed     = 16;
    localparam int n_random       = 40;
    localparam int worst_lat      = 10;  // ready stall plus valid delay for one word, in cycles
    localparam int timeout_cycles = (n_directed + n_random) * worst_lat * 8;

    logic             clk;
    logic             rst;
    cache_pkg::word_t req_addr;
    logic             req_ren;
    logic             req_wen;
    cache_pkg::mask_t req_mask;
    cache_pkg::word_t req_wdata;
    logic             busy;
    cache_pkg::word_t res_rdata;
    logic             mem_ready;
    cache_pkg::word_t mem_addr;
    logic             mem_ren;
    logic             mem_wen;
    cache_pkg::word_t mem_wdata;
    cache_pkg::word_t mem_rdata;
    logic             mem_valid;

    // shadow of memory and of the tag, valid and victim state
    cache_pkg::word_t shadow    [1024];
    cache_pkg::tag_t  sh_tag    [2][cache_pkg::num_sets];
    logic             sh_valid  [2][cache_pkg::num_sets];
    logic             sh_victim [cache_pkg::num_sets];

    // what the bus monitor expects for the request in flight
    cache_pkg::word_t exp_line;
    cache_pkg::word_t exp_wr_addr;
    cache_pkg::word_t exp_wr_data;
    int               rd_cnt;
    int               wr_cnt;
    cache_pkg::word_t rng = lcg_seed;

    cache_top uut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_req_addr  (req_addr),
        .i_req_ren   (req_ren),
        .i_req_wen   (req_wen),
        .i_req_mask  (req_mask),
        .i_req_wdata (req_wdata),
        .o_busy      (busy),
        .o_res_rdata (res_rdata),
        .i_mem_ready (mem_ready),
        .o_mem_addr  (mem_addr),
        .o_mem_ren   (mem_ren),
        .o_mem_wen   (mem_wen),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata),
        .i_mem_valid (mem_valid)
    );

    tb_mem_model #(.mem_base(mem_base), .lcg_seed(lcg_seed)) u_mem (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_ren   (mem_ren),
        .i_wen   (mem_wen),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_ready (mem_ready),
        .o_valid (mem_valid),
        .o_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // failure reporting helpers
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic expect_val(input string name, input cache_pkg::word_t exp,
                              input cache_pkg::word_t act);
        assert (act === exp) else
            abort_run($sformatf("ERR %0t ns %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic require(input logic cond, input string why);
        assert (cond === 1'b1) else abort_run(why);
    endtask

    function automatic cache_pkg::word_t lcg_next(input cache_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // bytes with their mask bit set come from the store, the rest stay as they were
    function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old,
                                                     input cache_pkg::word_t wdata,
                                                     input cache_pkg::mask_t m);
        cache_pkg::word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) r[8*b +: 8] = wdata[8*b +: 8];
        end
        return r;
    endfunction

    //////////////////////////////
    // memory bus monitor
    //////////////////////////////

    // sampled mid cycle where the combinational outputs have settled
    always @(negedge clk) begin
        if (!rst) begin
            require(!(mem_ren && mem_wen), "memory read and write pulsed in the same cycle");
            if (mem_ren || mem_wen) require(mem_ready, "memory pulse while ready was low");
            if (mem_ren) begin
                require(rd_cnt < 4, "refill issued more than four reads");
                expect_val("o_mem_addr", exp_line + 32'(4 * rd_cnt), mem_addr);
                rd_cnt++;
            end
            if (mem_wen) begin
                expect_val("o_mem_addr", exp_wr_addr, mem_addr);
                expect_val("o_mem_wdata", exp_wr_data, mem_wdata);
                wr_cnt++;
            end
        end
    end

    // one hart request, checked against the shadow model and then folded into it
    task automatic run_req(input cache_pkg::word_t addr, input logic is_store,
                           input cache_pkg::mask_t mask, input cache_pkg::word_t wdata);
        cache_pkg::set_idx_t set;
        cache_pkg::tag_t     tag;
        logic [9:0]          idx;
        logic                hit;
        logic                way;
        cache_pkg::word_t    merged;
        set = addr[8:4];
        tag = addr[31:9];
        idx = addr[11:2];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[w][set] && sh_tag[w][set] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        // a load ignores its mask and sees the stored word
        merged      = is_store ? merge_bytes(shadow[idx], wdata, mask) : shadow[idx];
        rd_cnt      = 0;
        wr_cnt      = 0;
        exp_line    = {addr[31:4], 4'h0};
        exp_wr_addr = {addr[31:2], 2'b00};
        exp_wr_data = merged;
        @(posedge clk);
        req_addr  <= addr;
        req_ren   <= !is_store;
        req_wen   <= is_store;
        req_mask  <= mask;
        req_wdata <= wdata;
        @(negedge clk);
        if (hit) begin
            if (!is_store) begin
                expect_val("o_busy", 1'b0, busy);
                expect_val("o_res_rdata", merged, res_rdata);  // data in the request cycle
            end
            while (busy) begin
                // a store hit may only wait on memory
                require(!mem_ready, "store hit stalled while memory was ready");
                @(negedge clk);
            end
        end else begin
            expect_val("o_busy", 1'b1, busy);  // a miss stalls at once
        end
        @(posedge clk);
        req_ren <= 1'b0;
        req_wen <= 1'b0;
        if (!hit) begin
            do @(negedge clk); while (busy);
            expect_val("o_res_rdata", merged, res_rdata);
        end
        expect_val("refill read count", hit ? 0 : 4, rd_cnt);
        expect_val("write-through count", is_store, wr_cnt);
        if (is_store) shadow[idx] = merged;
        if (hit) begin
            sh_victim[set] = ~way;
        end else begin
            way               = sh_victim[set];   // the fill lands in the victim way
            sh_tag[way][set]  = tag;
            sh_valid[way][set] = 1'b1;
            sh_victim[set]    = ~way;
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        cache_pkg::word_t addr;
        cache_pkg::word_t ctl;
        rst       = 1'b1;
        req_addr  = '0;
        req_ren   = 1'b0;
        req_wen   = 1'b0;
        req_mask  = '0;
        req_wdata = '0;
        rd_cnt    = 0;
        wr_cnt    = 0;
        for (int s = 0; s < cache_pkg::num_sets; s++) begin
            sh_valid[0][s] = 1'b0;
            sh_valid[1][s] = 1'b0;
            sh_victim[s]   = 1'b0;   // every set starts out replacing way 0
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_val("o_busy", 1'b0, busy);
        expect_val("o_mem_ren", 1'b0, mem_ren);
        expect_val("o_mem_wen", 1'b0, mem_wen);
        for (int i = 0; i < 1024; i++) shadow[i] = u_mem.words[i];

        // cold miss, then a second word of the same line
        run_req(mem_base + 32'h14, 1'b0, 4'h0, '0);
        run_req(mem_base + 32'h1c, 1'b0, 4'h0, '0);
        // store hits with bytes and halves, then read the merged word back
        run_req(mem_base + 32'h14, 1'b1, 4'b0001, 32'h1122_3344);
        run_req(mem_base + 32'h14, 1'b1, 4'b1100, 32'h5566_7788);
        run_req(mem_base + 32'h14, 1'b1, 4'b0110, 32'h99aa_bbcc);
        run_req(mem_base + 32'h14, 1'b1, 4'b1000, 32'hddee_ff00);
        run_req(mem_base + 32'h14, 1'b1, 4'b1111, 32'hcafe_f00d);
        run_req(mem_base + 32'h14, 1'b0, 4'h0, '0);
        // store miss merges into the refilled line
        run_req(mem_base + 32'h38, 1'b1, 4'b0010, 32'h0000_ab00);
        run_req(mem_base + 32'h38, 1'b0, 4'h0, '0);
        // three tags fighting over set 5
        run_req(mem_base + 32'h050, 1'b0, 4'h0, '0);
        run_req(mem_base + 32'h250, 1'b0, 4'h0, '0);
        run_req(mem_base + 32'h050, 1'b0, 4'h0, '0);
        run_req(mem_base + 32'h450, 1'b0, 4'h0, '0);
        run_req(mem_base + 32'h250, 1'b0, 4'h0, '0);
        run_req(mem_base + 32'h050, 1'b0, 4'h0, '0);

        // random mix over 8 sets and 4 tags per set
        for (int i = 0; i < n_random; i++) begin
            rng  = lcg_next(rng);
            addr = mem_base + ((rng >> 16) & 32'h0000_067c);
            rng  = lcg_next(rng);
            ctl  = rng;
            rng  = lcg_next(rng);
            run_req(addr, ctl[31], ctl[30:27], rng);
        end

        $display("Test passed");
        $finish;
    end

    // bounds the run by the request count and the slowest memory answer
    initial begin
        repeat (timeout_cycles + 8) @(posedge clk);
        abort_run("watchdog expired before all requests completed");
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] mem_base = 32'h0001_0000,
    parameter logic [31:0] lcg_seed = 32'h21befb5a
) (
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic        i_ren,
    input  wire logic        i_wen,
    input  wire logic [31:0] i_addr,
    input  wire logic [31:0] i_wdata,
    output logic             o_ready,
    output logic             o_valid,
    output logic [31:0]      o_rdata
);

    logic [31:0] words [1024];        // 4 KiB window starting at mem_base
    logic [31:0] rng      = lcg_seed;
    logic        ready_q  = 1'b0;
    logic        valid_q  = 1'b0;
    logic [31:0] rdata_q  = '0;
    logic        pending  = 1'b0;     // a read was taken and its word is not back yet
    logic [1:0]  wait_cnt = '0;       // extra cycles before the word returns
    logic [9:0]  rd_idx   = '0;
    logic [1:0]  low_run  = '0;       // ready low cycles in a row

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every bit of the byte address feeds the word it holds
    function automatic logic [31:0] fill_pattern(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            words[i] = fill_pattern(mem_base + 32'(i) * 32'd4);
        end
    end

    assign o_ready = ready_q;
    assign o_valid = valid_q;
    assign o_rdata = rdata_q;

    always @(posedge i_clk) begin
        rng     <= next_rand(rng);
        valid_q <= 1'b0;                                    // valid is a single cycle pulse
        // ready drops about one cycle in four, never more than three in a row
        if (low_run == 2'd3 || rng[31:30] != 2'b00) begin
            ready_q <= 1'b1;
            low_run <= 2'd0;
        end else begin
            ready_q <= 1'b0;
            low_run <= low_run + 2'd1;
        end
        if (i_rst) begin
            pending <= 1'b0;
        end else begin
            if (i_wen) begin
                words[i_addr[11:2]] <= i_wdata;             // writes get no answer
            end
            if (i_ren) begin
                pending  <= 1'b1;
                rd_idx   <= i_addr[11:2];
                wait_cnt <= rng[29:28];
            end else if (pending) begin
                if (wait_cnt == 2'd0) begin
                    valid_q <= 1'b1;
                    rdata_q <= words[rd_idx];
                    pending <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
